// ==== common/pma_pkg.sv ====
// pma checker package: region count, address widths, config encodings and region types

package pma_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////

  // number of attribute regions
  localparam int PMA_CNT   = 8;
  // width of a region index
  localparam int PMA_IDX_W = $clog2(PMA_CNT);
  // physical address width in bits
  localparam int PLEN      = 34;
  // region address register and bus word width
  localparam int XLEN      = 32;
  // wishbone byte address, two words per region
  localparam int WB_ADR_W  = 6;

  //////////////////////////////////////////////////////////////////////
  // config word layout
  //////////////////////////////////////////////////////////////////////

  // mode sits in bits 1:0, memory type in bits 3:2
  localparam int CFG_MODE_LSB = 0;
  localparam int CFG_MEM_LSB  = 2;
  // permission and flag bits
  localparam int CFG_R_BIT    = 4;
  localparam int CFG_W_BIT    = 5;
  localparam int CFG_X_BIT    = 6;
  localparam int CFG_C_BIT    = 7;
  localparam int CFG_M_BIT    = 8;

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////

  // physical byte address
  typedef logic [PLEN-1:0]      paddr_t;
  // region address, byte address >> 2
  typedef logic [XLEN-1:0]      pmaaddr_t;
  // bus word
  typedef logic [XLEN-1:0]      wb_data_t;
  // region number
  typedef logic [PMA_IDX_W-1:0] pma_idx_t;

  // address match mode
  typedef enum logic [1:0] {
    OFF   = 2'd0,
    TOR   = 2'd1,
    NA4   = 2'd2,
    NAPOT = 2'd3
  } pma_mode_e;

  // memory type, encoding 3 unused
  typedef enum logic [1:0] {
    MEM_EMPTY = 2'd0,
    MEM_MAIN  = 2'd1,
    MEM_IO    = 2'd2
  } mem_type_e;

  // access size, 1/2/4/8 bytes
  typedef enum logic [1:0] {
    BYTE  = 2'd0,
    HWORD = 2'd1,
    WORD  = 2'd2,
    DWORD = 2'd3
  } access_size_e;

  // normalized attributes of one region
  typedef struct packed {
    logic r;
    logic w;
    logic x;
    logic m;
    logic c;
  } pma_attr_t;

  // everything a matcher and the selector need about one region
  typedef struct packed {
    pma_mode_e mode;
    pmaaddr_t  pmaaddr;
    paddr_t    tor_base;
    pma_attr_t attr;
  } pma_region_t;

endpackage

// ==== pma_checker.f ====
common/pma_pkg.sv
pma_front/pma_cfg_front.sv
pma_match/pma_region_match.sv
pma_match/pma_priority_sel.sv
source/pma_checker.sv
test/pma_checker_tb.sv

// ==== pma_front/pma_cfg_front.sv ====
// pma config front: wishbone region registers, attribute normalization, access bounds

`timescale 1ns/10ps

module pma_cfg_front
  import pma_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,

  // wishbone classic slave
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  logic [WB_ADR_W-1:0] wb_adr_i,
  input  wb_data_t            wb_dat_i,
  output wb_data_t            wb_dat_o,
  output logic                wb_ack_o,

  // access request
  input  logic                stall_i,
  input  logic                access_valid_i,
  input  paddr_t              access_adr_i,
  input  access_size_e        access_size_i,

  // to the matchers and the selector
  output pma_region_t         region_o [PMA_CNT],
  output paddr_t              access_lb_o,
  output paddr_t              access_ub_o,
  output logic                advance_o
);

  // raw register file
  wb_data_t cfg_q [PMA_CNT];
  pmaaddr_t adr_q [PMA_CNT];

  logic     wb_req;
  pma_idx_t wb_idx;
  wb_data_t rd_data;
  paddr_t   size_bytes;

  //////////////////////////////////////////////////////////////////////
  // wishbone register file
  //////////////////////////////////////////////////////////////////////

  // new request only while no ack is out
  assign wb_req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  // region number in bits 5:3, bit 2 picks the address word
  assign wb_idx = wb_adr_i[WB_ADR_W-1:3];

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wb_ack_o <= 1'b0;
      // all regions OFF, no attributes
      cfg_q    <= '{default: '0};
      adr_q    <= '{default: '0};
    end
    else
    begin
      // single cycle ack
      wb_ack_o <= wb_req;
      // write lands on the same edge as the ack
      if (wb_req && wb_we_i)
      begin
        if (wb_adr_i[2])
          adr_q[wb_idx] <= wb_dat_i;
        else
          cfg_q[wb_idx] <= wb_dat_i;
      end
    end
  end

  // config reads return the raw word
  assign rd_data = wb_adr_i[2] ? adr_q[wb_idx] : cfg_q[wb_idx];

  // read data held for the ack cycle
  always_ff @(posedge clk_i)
  begin
    if (wb_req && !wb_we_i)
      wb_dat_o <= rd_data;
  end

  //////////////////////////////////////////////////////////////////////
  // region normalization
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < PMA_CNT; i++)
  begin : g_region
    mem_type_e mem;
    pma_attr_t attr;
    paddr_t    tor_base;

    assign mem = mem_type_e'(cfg_q[i][CFG_MEM_LSB +: 2]);

    always_comb
    begin
      // empty memory grants nothing
      attr.r = (mem == MEM_EMPTY) ? 1'b0 : cfg_q[i][CFG_R_BIT];
      attr.w = (mem == MEM_EMPTY) ? 1'b0 : cfg_q[i][CFG_W_BIT];
      attr.x = (mem == MEM_EMPTY) ? 1'b0 : cfg_q[i][CFG_X_BIT];
      attr.m = cfg_q[i][CFG_M_BIT];
      // only main memory may be cached
      attr.c = (mem == MEM_MAIN) ? cfg_q[i][CFG_C_BIT] : 1'b0;
    end

    // TOR base is the previous region's top
    if (i == 0)
    begin : g_base_zero
      assign tor_base = '0;
    end
    else
    begin : g_base_prev
      assign tor_base = {adr_q[i-1], 2'b00};
    end

    assign region_o[i] = '{
      mode:     pma_mode_e'(cfg_q[i][CFG_MODE_LSB +: 2]),
      pmaaddr:  adr_q[i],
      tor_base: tor_base,
      attr:     attr
    };
  end

  //////////////////////////////////////////////////////////////////////
  // access bounds
  //////////////////////////////////////////////////////////////////////

  // bytes covered by the access
  always_comb
  begin
    case (access_size_i)
      BYTE:    size_bytes = paddr_t'(1);
      HWORD:   size_bytes = paddr_t'(2);
      WORD:    size_bytes = paddr_t'(4);
      default: size_bytes = paddr_t'(8);
    endcase
  end

  assign access_lb_o = access_adr_i;
  // inclusive last byte
  assign access_ub_o = access_adr_i + size_bytes - paddr_t'(1);

  // pipeline moves on a valid, unstalled access
  assign advance_o = access_valid_i & ~stall_i;

endmodule

// ==== pma_match/pma_priority_sel.sv ====
// pma priority select: lowest matching region and the exception, misaligned, cacheable results

`timescale 1ns/10ps

module pma_priority_sel
  import pma_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_n_i,

  input  logic [PMA_CNT-1:0] match_i,
  input  pma_region_t        region_i [PMA_CNT],
  input  logic               advance_i,
  input  logic               stall_i,

  // access flags, same stage as the bounds
  input  logic               access_instr_i,
  input  logic               access_we_i,
  input  logic               access_misaligned_i,

  output logic               result_valid_o,
  output logic               exception_o,
  output logic               misaligned_o,
  output logic               cacheable_o
);

  logic      instr_q;
  logic      we_q;
  logic      misaligned_q;
  logic      hit;
  pma_idx_t  sel_idx;
  pma_attr_t sel_attr;

  //////////////////////////////////////////////////////////////////////
  // flag stage, in step with the matchers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      result_valid_o <= 1'b0;
    // falls on an idle cycle, holds on stall
    else if (!stall_i)
      result_valid_o <= advance_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (advance_i)
    begin
      instr_q      <= access_instr_i;
      we_q         <= access_we_i;
      misaligned_q <= access_misaligned_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // priority pick
  //////////////////////////////////////////////////////////////////////

  assign hit = |match_i;

  // scan downwards so the lowest set bit wins
  always_comb
  begin
    sel_idx = '0;
    for (int n = PMA_CNT - 1; n >= 0; n--)
    begin
      if (match_i[n])
        sel_idx = pma_idx_t'(n);
    end
  end

  assign sel_attr = region_i[sel_idx].attr;

  //////////////////////////////////////////////////////////////////////
  // results
  //////////////////////////////////////////////////////////////////////

  // no region, or a missing permission
  assign exception_o = ~hit                     |
                       ( instr_q & ~sel_attr.x) |
                       ( we_q    & ~sel_attr.w) |
                       (~we_q    & ~sel_attr.r);

  // unmatched misaligned accesses stay refused
  assign misaligned_o = hit ? (misaligned_q & ~sel_attr.m) : misaligned_q;

  assign cacheable_o = hit & sel_attr.c;

endmodule

// ==== pma_match/pma_region_match.sv ====
// pma region matcher: one region's bounds and a registered all-bytes containment flag

`timescale 1ns/10ps

module pma_region_match
  import pma_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  pma_region_t region_i,
  input  paddr_t      access_lb_i,
  input  paddr_t      access_ub_i,
  input  logic        advance_i,

  output logic        match_o
);

  // all bounds in 4-byte words, two spare bits so a full NAPOT top still fits
  logic [XLEN+1:0] acc_lb_w;
  logic [XLEN+1:0] acc_ub_w;
  logic [XLEN+1:0] adr_w;
  logic [XLEN+1:0] napot_low;
  logic [XLEN+1:0] napot_lb;
  logic [XLEN+1:0] napot_ub;
  logic [XLEN+1:0] reg_lb_w;
  logic [XLEN+1:0] reg_ub_w;
  logic            match_d;

  //////////////////////////////////////////////////////////////////////
  // access in words
  //////////////////////////////////////////////////////////////////////

  assign acc_lb_w = {2'b00, access_lb_i[PLEN-1:2]};
  // last word touched by the access
  assign acc_ub_w = {2'b00, access_ub_i[PLEN-1:2]};

  //////////////////////////////////////////////////////////////////////
  // NAPOT decode
  //////////////////////////////////////////////////////////////////////

  assign adr_w = {2'b00, region_i.pmaaddr};

  // t trailing ones plus the first zero give t+1 low ones
  assign napot_low = adr_w ^ (adr_w + 1'b1);

  // base with the low t+3 byte bits cleared
  assign napot_lb = adr_w & ~napot_low;

  // 2^(t+1) words past the base, exclusive
  assign napot_ub = napot_lb + napot_low + 1'b1;

  //////////////////////////////////////////////////////////////////////
  // region bounds, upper exclusive
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (region_i.mode)
      TOR:
      begin
        // from the previous region's address up to ours
        reg_lb_w = {2'b00, region_i.tor_base[PLEN-1:2]};
        reg_ub_w = adr_w;
      end
      NA4:
      begin
        // a single word
        reg_lb_w = adr_w;
        reg_ub_w = adr_w + 1'b1;
      end
      NAPOT:
      begin
        reg_lb_w = napot_lb;
        reg_ub_w = napot_ub;
      end
      default:
      begin
        // OFF never matches
        reg_lb_w = '0;
        reg_ub_w = '0;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // containment
  //////////////////////////////////////////////////////////////////////

  // every byte of the access must lie inside
  assign match_d = (region_i.mode != OFF) &&
                   (reg_lb_w <= acc_lb_w) &&
                   (acc_ub_w < reg_ub_w);

  // held while the pipeline stalls or idles
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      match_o <= 1'b0;
    else if (advance_i)
      match_o <= match_d;
  end

endmodule

// ==== source/pma_checker.sv ====
// pma checker top: wishbone configured region checker with a one-cycle result

`timescale 1ns/10ps

module pma_checker
  import pma_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,

  // wishbone classic slave
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  logic [WB_ADR_W-1:0] wb_adr_i,
  input  wb_data_t            wb_dat_i,
  output wb_data_t            wb_dat_o,
  output logic                wb_ack_o,

  // access port
  input  logic                access_valid_i,
  input  paddr_t              access_adr_i,
  input  access_size_e        access_size_i,
  input  logic                access_instr_i,
  input  logic                access_we_i,
  input  logic                access_misaligned_i,
  input  logic                stall_i,

  // results, one cycle after the access
  output logic                result_valid_o,
  output logic                exception_o,
  output logic                misaligned_o,
  output logic                cacheable_o
);

  pma_region_t        region [PMA_CNT];
  paddr_t             access_lb;
  paddr_t             access_ub;
  logic               advance;
  logic [PMA_CNT-1:0] match;

  ////////////////////////////////////////////////////////////////////
  // feeder
  ////////////////////////////////////////////////////////////////////

  pma_cfg_front u_front (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_dat_o       (wb_dat_o),
    .wb_ack_o       (wb_ack_o),
    .stall_i        (stall_i),
    .access_valid_i (access_valid_i),
    .access_adr_i   (access_adr_i),
    .access_size_i  (access_size_i),
    .region_o       (region),
    .access_lb_o    (access_lb),
    .access_ub_o    (access_ub),
    .advance_o      (advance)
  );

  ////////////////////////////////////////////////////////////////////
  // one matcher per region
  ////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < PMA_CNT; i++)
  begin : g_match
    pma_region_match u_match (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .region_i    (region[i]),
      .access_lb_i (access_lb),
      .access_ub_i (access_ub),
      .advance_i   (advance),
      .match_o     (match[i])
    );
  end

  ////////////////////////////////////////////////////////////////////
  // drain
  ////////////////////////////////////////////////////////////////////

  pma_priority_sel u_sel (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .match_i             (match),
    .region_i            (region),
    .advance_i           (advance),
    .stall_i             (stall_i),
    .access_instr_i      (access_instr_i),
    .access_we_i         (access_we_i),
    .access_misaligned_i (access_misaligned_i),
    .result_valid_o      (result_valid_o),
    .exception_o         (exception_o),
    .misaligned_o        (misaligned_o),
    .cacheable_o         (cacheable_o)
  );

endmodule

// ==== test/pma_checker_tb.sv ====
// pma checker testbench: wishbone setup, region decode, priority, misaligned and stall checks

`timescale 1ns/10ps

module pma_checker_tb
  import pma_pkg::*;
;

  // planned run length
  localparam int BUS_OPS        = 80;
  localparam int BUS_OP_CYCLES  = 4;
  localparam int ACCESS_CYCLES  = 8 + 256 + 200 + 100 + 300;
  localparam int IDLE_CYCLES    = 40;
  localparam int TIMEOUT_CYCLES = 2 * (BUS_OPS * BUS_OP_CYCLES + ACCESS_CYCLES + IDLE_CYCLES);

  logic                clk_i;
  logic                rst_n_i;
  logic                wb_cyc_i;
  logic                wb_stb_i;
  logic                wb_we_i;
  logic [WB_ADR_W-1:0] wb_adr_i;
  wb_data_t            wb_dat_i;
  wb_data_t            wb_dat_o;
  logic                wb_ack_o;
  logic                access_valid_i;
  paddr_t              access_adr_i;
  access_size_e        access_size_i;
  logic                access_instr_i;
  logic                access_we_i;
  logic                access_misaligned_i;
  logic                stall_i;
  logic                result_valid_o;
  logic                exception_o;
  logic                misaligned_o;
  logic                cacheable_o;

  // copy of what software wrote
  wb_data_t cfg_copy [PMA_CNT];
  pmaaddr_t adr_copy [PMA_CNT];

  // expected {exception, misaligned, cacheable}, oldest first
  logic [2:0] exp_q [$];

  int errors;
  int checks;
  int cycle_cnt;
  int req_cnt;
  int ack_cnt;

  // byte boundaries of the decode regions
  int boundary [8] = '{32'h1000, 32'h2000, 32'h4000, 32'h4004,
                       32'h8000, 32'h8100, 32'h10000, 32'h10008};

  pma_checker uut (.*);

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycle_cnt++;
    // ack seen high at an edge, one count per pulse
    if (wb_ack_o)
      ack_cnt++;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // config word from its fields
  function automatic wb_data_t cfg_word(input pma_mode_e mode, input mem_type_e mem,
                                        input logic r, input logic w, input logic x,
                                        input logic c, input logic m);
    return {23'd0, m, c, x, w, r, 2'(mem), 2'(mode)};
  endfunction

  function automatic logic [2:0] expected_result(input paddr_t adr, input logic [1:0] size,
                                                 input logic instr, input logic we,
                                                 input logic mis);
    longint unsigned first;
    longint unsigned last;
    longint unsigned lo;
    longint unsigned hi;
    longint unsigned span;
    int              ones;
    logic [1:0]      mode;
    logic [1:0]      mem;
    logic            r;
    logic            w;
    logic            x;
    logic            exc;
    first = 64'(adr);
    // last byte, wraps in the 34-bit space
    last = (first + (64'd1 << size) - 64'd1) & ((64'd1 << PLEN) - 64'd1);
    for (int i = 0; i < PMA_CNT; i++)
    begin
      mode = cfg_copy[i][1:0];
      mem  = cfg_copy[i][3:2];
      if (mode == 2'd1)
      begin
        // TOR, below our address and from the neighbor's
        lo = (i == 0) ? 64'd0 : 64'(adr_copy[i-1]) << 2;
        hi = 64'(adr_copy[i]) << 2;
      end
      else if (mode == 2'd2)
      begin
        lo = 64'(adr_copy[i]) << 2;
        hi = lo + 64'd4;
      end
      else if (mode == 2'd3)
      begin
        ones = 0;
        while (ones < 32 && adr_copy[i][ones])
          ones++;
        span = 64'd8 << ones;
        lo   = (64'(adr_copy[i]) << 2) & ~(span - 64'd1);
        hi   = lo + span;
      end
      else
      begin
        // OFF, empty window
        lo = 64'd1;
        hi = 64'd0;
      end
      if (lo <= first && last < hi)
      begin
        r   = (mem == 2'd0) ? 1'b0 : cfg_copy[i][4];
        w   = (mem == 2'd0) ? 1'b0 : cfg_copy[i][5];
        x   = (mem == 2'd0) ? 1'b0 : cfg_copy[i][6];
        exc = (instr & ~x) | (we & ~w) | (~we & ~r);
        return {exc, mis & ~cfg_copy[i][8], (mem == 2'd1) & cfg_copy[i][7]};
      end
    end
    // nothing contains it
    return {1'b1, mis, 1'b0};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // result compare
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i)
  begin : compare
    logic [2:0] want;
    if (rst_n_i && result_valid_o)
    begin
      if (exp_q.size() == 0)
      begin
        $display("result_valid_o high at %0t with no access outstanding", $time);
        errors++;
      end
      else
      begin
        want = exp_q[0];
        checks++;
        if (exception_o !== want[2])
        begin
          $display("FAIL %0t exception_o got %b expected %b", $time, exception_o, want[2]);
          errors++;
        end
        if (misaligned_o !== want[1])
        begin
          $display("FAIL %0t misaligned_o got %b expected %b", $time, misaligned_o, want[1]);
          errors++;
        end
        if (cacheable_o !== want[0])
        begin
          $display("FAIL %0t cacheable_o got %b expected %b", $time, cacheable_o, want[0]);
          errors++;
        end
        // stalled result stays and is checked again
        if (!stall_i)
          void'(exp_q.pop_front());
      end
    end
    if (rst_n_i && access_valid_i && !stall_i)
      exp_q.push_back(expected_result(access_adr_i, access_size_i, access_instr_i,
                                      access_we_i, access_misaligned_i));
  end

  //////////////////////////////////////////////////////////////////////
  // wishbone tasks
  //////////////////////////////////////////////////////////////////////

  task automatic bus_cycle(input int adr, input logic we, input wb_data_t data,
                           output wb_data_t rdata);
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr[WB_ADR_W-1:0];
    wb_dat_i = data;
    req_cnt++;
    do
      @(negedge clk_i);
    while (!wb_ack_o);
    rdata    = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    @(negedge clk_i);
    if (wb_ack_o)
    begin
      $display("wb_ack_o held longer than one cycle at %0t", $time);
      errors++;
    end
  endtask

  task automatic read_check(input int adr, input wb_data_t want);
    wb_data_t got;
    bus_cycle(adr, 1'b0, '0, got);
    if (got !== want)
    begin
      $display("FAIL %0t wb_dat_o got %h expected %h", $time, got, want);
      errors++;
    end
  endtask

  task automatic load_config();
    wb_data_t unused;
    for (int i = 0; i < PMA_CNT; i++)
    begin
      bus_cycle(i * 8, 1'b1, cfg_copy[i], unused);
      bus_cycle(i * 8 + 4, 1'b1, adr_copy[i], unused);
    end
  endtask

  task automatic read_all();
    for (int i = 0; i < PMA_CNT; i++)
    begin
      read_check(i * 8, cfg_copy[i]);
      read_check(i * 8 + 4, adr_copy[i]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // access tasks
  //////////////////////////////////////////////////////////////////////

  task automatic send_access(input paddr_t adr, input logic [1:0] size, input logic instr,
                             input logic we, input logic mis);
    @(negedge clk_i);
    access_valid_i      = 1'b1;
    stall_i             = 1'b0;
    access_adr_i        = adr;
    access_size_i       = access_size_e'(size);
    access_instr_i      = instr;
    access_we_i         = we;
    access_misaligned_i = mis;
  endtask

  task automatic go_idle(input int n);
    repeat (n)
    begin
      @(negedge clk_i);
      access_valid_i = 1'b0;
      stall_i        = 1'b0;
    end
  endtask

  // a random access inside the phase 3 window
  task automatic send_local(input logic mis);
    send_access(paddr_t'($urandom_range(32'h1ff00, 32'h20500)), 2'($urandom_range(0, 3)),
                1'($urandom), 1'($urandom), mis);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial
  begin : main
    logic [1:0] top_bits;
    clk_i               = 1'b0;
    rst_n_i             = 1'b0;
    wb_cyc_i            = 1'b0;
    wb_stb_i            = 1'b0;
    wb_we_i             = 1'b0;
    wb_adr_i            = '0;
    wb_dat_i            = '0;
    access_valid_i      = 1'b0;
    access_adr_i        = '0;
    access_size_i       = BYTE;
    access_instr_i      = 1'b0;
    access_we_i         = 1'b0;
    access_misaligned_i = 1'b0;
    stall_i             = 1'b0;
    void'($urandom(32'hdcf5c811));
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // 1. nothing active after reset, then register readback
    cfg_copy = '{default: '0};
    adr_copy = '{default: '0};
    repeat (8)
      send_access(paddr_t'($urandom), 2'($urandom_range(0, 3)), 1'b0, 1'($urandom), 1'b0);
    go_idle(2);
    read_all();
    for (int i = 0; i < PMA_CNT; i++)
    begin
      cfg_copy[i] = $urandom;
      adr_copy[i] = $urandom;
    end
    load_config();
    read_all();

    // 2. TOR, NA4 and NAPOT edges
    cfg_copy    = '{default: '0};
    adr_copy    = '{default: '0};
    adr_copy[0] = 32'h400;
    cfg_copy[0] = cfg_word(OFF, MEM_MAIN, 1, 1, 1, 1, 1);
    adr_copy[1] = 32'h800;
    cfg_copy[1] = cfg_word(TOR, MEM_MAIN, 1, 1, 1, 1, 1);
    adr_copy[2] = 32'h1000;
    cfg_copy[2] = cfg_word(NA4, MEM_MAIN, 1, 1, 0, 1, 0);
    // 256 bytes at 0x8000
    adr_copy[3] = 32'h201f;
    cfg_copy[3] = cfg_word(NAPOT, MEM_IO, 1, 1, 1, 0, 1);
    // 8 bytes at 0x10000
    adr_copy[4] = 32'h4000;
    cfg_copy[4] = cfg_word(NAPOT, MEM_MAIN, 1, 1, 1, 1, 1);
    load_config();
    for (int b = 0; b < 8; b++)
      for (int off = -4; off < 4; off++)
        for (int sz = 0; sz < 4; sz++)
          send_access(paddr_t'(boundary[b] + off), 2'(sz), 1'($urandom), 1'($urandom), 1'b0);
    go_idle(3);

    // 3. overlapping regions around 0x20000
    cfg_copy    = '{default: '0};
    adr_copy    = '{default: '0};
    adr_copy[0] = 32'h8000;
    cfg_copy[0] = cfg_word(NA4, MEM_EMPTY, 1, 1, 1, 1, 1);
    adr_copy[1] = 32'h8005;
    cfg_copy[1] = cfg_word(NAPOT, MEM_IO, 1, 1, 0, 1, 0);
    adr_copy[2] = 32'h8007;
    cfg_copy[2] = cfg_word(NAPOT, MEM_MAIN, 1, 0, 1, 1, 1);
    adr_copy[3] = 32'h801f;
    cfg_copy[3] = cfg_word(NAPOT, MEM_MAIN, 1, 1, 1, 0, 0);
    // unused memory type keeps rwx but loses c
    adr_copy[4] = 32'h8100;
    cfg_copy[4] = cfg_word(TOR, mem_type_e'(2'd3), 1, 1, 1, 1, 1);
    // 1 MB at zero
    adr_copy[5] = 32'h1ffff;
    cfg_copy[5] = cfg_word(NAPOT, MEM_MAIN, 1, 1, 0, 1, 1);
    load_config();
    repeat (200)
      send_local(1'($urandom));
    go_idle(3);

    // 4. misaligned refusal by m, then mostly unmatched addresses
    repeat (50)
      send_access(paddr_t'($urandom_range(32'h20000, 32'h200ff)), 2'($urandom_range(0, 3)),
                  1'b0, 1'($urandom), 1'b1);
    repeat (50)
    begin
      top_bits = 2'($urandom);
      send_access({top_bits, $urandom}, 2'($urandom_range(0, 3)), 1'($urandom),
                  1'($urandom), 1'($urandom));
    end
    go_idle(3);

    // 5. random valid and stall
    repeat (300)
    begin
      send_local(1'($urandom));
      access_valid_i = ($urandom_range(0, 99) < 75);
      stall_i        = ($urandom_range(0, 99) < 30);
    end
    go_idle(4);

    if (exp_q.size() != 0)
    begin
      $display("%0d expected results never arrived", exp_q.size());
      errors++;
    end
    if (result_valid_o)
    begin
      $display("result_valid_o still high after the pipeline drained");
      errors++;
    end
    if (ack_cnt != req_cnt)
    begin
      $display("%0d acks seen for %0d bus requests", ack_cnt, req_cnt);
      errors++;
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // run limit
  initial
  begin : watchdog
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("timeout after %0d cycles, the run did not finish", cycle_cnt);
    errors++;
    $display("%0d checks, %0d errors", checks, errors);
    $display("Test FAILED");
    $finish;
  end

endmodule
